//--- hdl/axi_wr_pkg.sv
`include "cache_config.svh"

package axi_wr_pkg;

   typedef logic [31:0]             axi_addr_t;
   typedef logic [`BE_DATA_W-1:0]   be_data_t;    // full back-end word
   typedef logic [`BE_DATA_W/8-1:0] be_strb_t;
   typedef logic [`AXI_ID_W-1:0]    axi_id_t;
   typedef logic [7:0]              axi_len_t;    // beats minus one
   typedef logic [2:0]              axi_size_t;   // log2 of bytes per beat
   typedef logic [1:0]              axi_burst_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

endpackage

//--- hdl/axi_write_channel.sv
`timescale 1ns/100ps

`include "cache_config.svh"

module axi_write_channel
   import cache_req_pkg::*;
   import axi_wr_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   wr_req_if.dst      in,
   output axi_id_t    awid,
   output axi_addr_t  awaddr,
   output axi_len_t   awlen,
   output axi_size_t  awsize,
   output axi_burst_t awburst,
   output logic [3:0] awcache,
   output logic       awvalid,
   input  logic       awready,
   output be_data_t   wdata,
   output be_strb_t   wstrb,
   output logic       wlast,
   output logic       wvalid,
   input  logic       wready,
   input  axi_resp_e  bresp,
   input  logic       bvalid,
   output logic       bready
);

   localparam int WORD_BYTES = `CACHE_DATA_W / 8;
   localparam int WORD_OFF_W = $clog2(WORD_BYTES);        // byte offset in a word
   localparam int BE_OFF_W   = $clog2(`BE_DATA_W / 8);    // byte offset in a beat
   localparam int LANES      = `BE_DATA_W / `CACHE_DATA_W;
   localparam int LANE_W     = BE_OFF_W - WORD_OFF_W;

   typedef enum logic [1:0] {
      idle,
      address,
      write,
      verify
   } state_t;

   state_t            state;
   wr_req_t           cur;          // store being written to memory
   logic              take;
   logic              resp_ok;
   logic [LANE_W-1:0] lane;

   assign resp_ok  = bvalid & (bresp == OKAY);
   assign in.ready = (state == idle) | ((state == verify) & resp_ok);  // no gap between stores
   assign take     = in.valid & in.ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= idle;
      end else begin
         case (state)
            idle: begin
               if (in.valid) begin
                  state <= address;
               end
            end
            address: begin
               if (awready) begin
                  state <= write;
               end
            end
            write: begin
               if (wready) begin
                  state <= verify;
               end
            end
            default: begin
               if (bvalid) begin
                  if (bresp != OKAY) begin
                     state <= address;         // error, resend the same store
                  end else if (in.valid) begin
                     state <= address;         // next store already waiting
                  end else begin
                     state <= idle;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         cur <= in.req;
      end
   end

   // one transaction at a time, phases follow the state
   assign awvalid = (state == address);
   assign wvalid  = (state == write);
   assign bready  = (state == verify);
   assign wlast   = wvalid;              // single beat

   // fixed attributes of a single-beat write
   assign awid    = axi_id_t'(`AXI_ID_VAL);
   assign awlen   = '0;
   assign awsize  = axi_size_t'(BE_OFF_W);
   assign awburst = axi_burst_t'(0);     // fixed burst
   assign awcache = 4'b0011;             // bufferable, modifiable

   assign awaddr = {cur.addr[`CACHE_ADDR_W-1:BE_OFF_W], {BE_OFF_W{1'b0}}};

   assign lane  = cur.addr[WORD_OFF_W +: LANE_W];   // which word of the beat
   assign wstrb = be_strb_t'(cur.wstrb) << (lane * WORD_BYTES);
   assign wdata = {LANES{cur.wdata}};               // same word in every lane

endmodule

//--- hdl/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// front-end store side
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// back-end memory bus
`define BE_DATA_W    64

// AXI write identifiers
`define AXI_ID_W     4
`define AXI_ID_VAL   0

// stores held between processor and memory
`define WBUF_DEPTH   4

`endif

//--- hdl/cache_req_pkg.sv
`include "cache_config.svh"

package cache_req_pkg;

   typedef logic [`CACHE_ADDR_W-1:0]   addr_t;   // byte address
   typedef logic [`CACHE_DATA_W-1:0]   word_t;
   typedef logic [`CACHE_DATA_W/8-1:0] strb_t;   // one bit per byte

   // one processor store, 68 bits
   typedef struct packed {
      addr_t addr;
      word_t wdata;
      strb_t wstrb;
   } wr_req_t;

endpackage

//--- hdl/cache_write_path.sv
`timescale 1ns/100ps

module cache_write_path
   import cache_req_pkg::*;
   import axi_wr_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       req_valid,
   output logic       req_ready,
   input  addr_t      req_addr,
   input  word_t      req_wdata,
   input  strb_t      req_wstrb,
   output axi_id_t    awid,
   output axi_addr_t  awaddr,
   output axi_len_t   awlen,
   output axi_size_t  awsize,
   output axi_burst_t awburst,
   output logic [3:0] awcache,
   output logic       awvalid,
   input  logic       awready,
   output be_data_t   wdata,
   output be_strb_t   wstrb,
   output logic       wlast,
   output logic       wvalid,
   input  logic       wready,
   input  axi_resp_e  bresp,
   input  logic       bvalid,
   output logic       bready
);

   wr_req_t  req_in;
   wr_req_if buffered ();    // buffer head to write channel

   assign req_in = '{addr: req_addr, wdata: req_wdata, wstrb: req_wstrb};

   write_buffer wbuf (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req_in),
      .out       (buffered)
   );

   axi_write_channel wchan (
      .clk     (clk),
      .reset   (reset),
      .in      (buffered),
      .awid    (awid),
      .awaddr  (awaddr),
      .awlen   (awlen),
      .awsize  (awsize),
      .awburst (awburst),
      .awcache (awcache),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wlast   (wlast),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready)
   );

endmodule

//--- hdl/wr_req_if.sv
`timescale 1ns/100ps

interface wr_req_if
   import cache_req_pkg::*;
();

   logic    valid;
   logic    ready;
   wr_req_t req;      // held steady until ready

   modport src (
      output valid,
      output req,
      input  ready
   );

   modport dst (
      input  valid,
      input  req,
      output ready
   );

endinterface

//--- hdl/write_buffer.sv
`timescale 1ns/100ps

`include "cache_config.svh"

module write_buffer
   import cache_req_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    req_valid,
   output logic    req_ready,
   input  wr_req_t req,
   wr_req_if.src   out
);

   localparam int DEPTH = `WBUF_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   wr_req_t          mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;                                 // wrap around
      end
      return ptr + 1'b1;
   endfunction

   assign req_ready = (count != CNT_W'(DEPTH));    // stall processor when full
   assign out.valid = (count != '0);
   assign out.req   = mem[rd_ptr];                  // oldest store first

   assign push = req_valid & req_ready;
   assign pop  = out.valid & out.ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // idle or push and pop together
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= req;
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the cache write path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module tb_cache_write_path -o tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- testbench/tb_cache_write_path.sv
`timescale 1ns/100ps

`include "cache_config.svh"

module tb_cache_write_path
   import cache_req_pkg::*;
   import axi_wr_pkg::*;
();

   localparam int ROWS = 8;

   typedef struct packed {
      addr_t      addr;
      word_t      data;
      strb_t      strb;
      logic [1:0] errs;    // error responses before OKAY
   } store_row_t;

   logic       clk;
   logic       reset;
   logic       req_valid;
   logic       req_ready;
   addr_t      req_addr;
   word_t      req_wdata;
   strb_t      req_wstrb;
   axi_id_t    awid;
   axi_addr_t  awaddr;
   axi_len_t   awlen;
   axi_size_t  awsize;
   axi_burst_t awburst;
   logic [3:0] awcache;
   logic       awvalid;
   logic       awready;
   be_data_t   wdata;
   be_strb_t   wstrb;
   logic       wlast;
   logic       wvalid;
   logic       wready;
   axi_resp_e  bresp;
   logic       bvalid;
   logic       bready;

   store_row_t rows [ROWS];
   logic       stall;           // slave holds awready low
   int         errors = 0;
   int         tests = 0;
   int         failed_tests = 0;
   int         done_rows = 0;
   int         cycles = 0;
   int         limit = 0;

   tb_clock clk_gen (.clk(clk));

   cache_write_path dut (.*);

   function automatic int timeout_cycles();
      int max_errs;
      max_errs = 0;
      foreach (rows[i]) begin
         if (int'(rows[i].errs) > max_errs) begin
            max_errs = int'(rows[i].errs);
         end
      end
      return ROWS * (max_errs + 1) * 20 + 100;
   endfunction

   function automatic axi_addr_t expected_awaddr(input addr_t addr);
      return {addr[31:3], 3'b000};     // back-end word aligned
   endfunction

   function automatic be_strb_t expected_wstrb(input addr_t addr, input strb_t strb);
      return addr[2] ? {strb, 4'h0} : {4'h0, strb};
   endfunction

   function automatic be_data_t expected_wdata(input word_t data);
      return {data, data};
   endfunction

   task automatic report_mismatch(input string msg);
      errors++;
      $display("FAILED at %0t ns: %s", $time, msg);
   endtask

   task automatic note_test(input string name, input int mark);
      tests++;
      if (errors != mark) begin
         failed_tests++;
      end
      $display("test %0d, %s: %s", tests, name, (errors == mark) ? "pass" : "fail");
   endtask

   task automatic check_aw(input axi_addr_t got_addr, input axi_addr_t exp_addr,
                           input axi_id_t id, input axi_len_t len, input axi_size_t size,
                           input axi_burst_t burst, input logic [3:0] cache);
      if (got_addr !== exp_addr) begin
         report_mismatch($sformatf("awaddr %h, expected %h", got_addr, exp_addr));
      end
      if (id !== axi_id_t'(`AXI_ID_VAL) || len !== 8'd0 || size !== 3'd3) begin
         report_mismatch($sformatf("awid %h awlen %h awsize %h wrong", id, len, size));
      end
      if (burst !== 2'b00 || cache !== 4'b0011) begin
         report_mismatch($sformatf("awburst %b awcache %b wrong", burst, cache));
      end
   endtask

   task automatic check_w(input be_data_t got_data, input be_data_t exp_data,
                          input be_strb_t got_strb, input be_strb_t exp_strb, input logic last);
      if (got_data !== exp_data) begin
         report_mismatch($sformatf("wdata %h, expected %h", got_data, exp_data));
      end
      if (got_strb !== exp_strb) begin
         report_mismatch($sformatf("wstrb %h, expected %h", got_strb, exp_strb));
      end
      if (last !== 1'b1) begin
         report_mismatch("wlast low during the W beat");
      end
   endtask

   task automatic hold_full(input int count);
      int mark;
      mark = errors;
      if (count != `WBUF_DEPTH + 1) begin
         report_mismatch($sformatf("req_ready fell after %0d stores, expected %0d",
                                   count, `WBUF_DEPTH + 1));
      end
      repeat (8) begin
         @(negedge clk);
         if (req_ready !== 1'b0) begin
            report_mismatch("req_ready rose while the slave was stalled");
         end
      end
      @(posedge clk);
      #1 stall = 1'b0;
      note_test("buffer full under stall", mark);
   endtask

   // AXI slave model with random handshake delays
   initial begin : axi_slave
      int unsigned delay;
      int          row;
      int          attempts;
      int          mark;
      row = 0;
      attempts = 0;
      mark = 0;
      @(negedge reset);
      while (row < ROWS) begin
         do @(negedge clk); while (awvalid !== 1'b1);
         while (stall) @(negedge clk);
         if (attempts == 0) begin
            mark = errors;
         end
         check_aw(awaddr, expected_awaddr(rows[row].addr), awid, awlen, awsize, awburst,
                  awcache);
         delay = $urandom_range(5, 0);
         repeat (delay) @(negedge clk);
         @(posedge clk);
         #1 awready = 1'b1;
         @(posedge clk);
         #1 awready = 1'b0;
         do @(negedge clk); while (wvalid !== 1'b1);
         check_w(wdata, expected_wdata(rows[row].data), wstrb,
                 expected_wstrb(rows[row].addr, rows[row].strb), wlast);
         delay = $urandom_range(5, 0);
         repeat (delay) @(negedge clk);
         @(posedge clk);
         #1 wready = 1'b1;
         @(posedge clk);
         #1 wready = 1'b0;
         do @(negedge clk); while (bready !== 1'b1);
         delay = $urandom_range(5, 0);
         repeat (delay) @(negedge clk);
         @(posedge clk);
         #1;
         bvalid = 1'b1;
         if (attempts < int'(rows[row].errs)) begin
            bresp = SLVERR;
         end else begin
            bresp = OKAY;
         end
         @(posedge clk);
         #1 bvalid = 1'b0;
         attempts++;
         if (attempts > int'(rows[row].errs)) begin     // store done once OKAY returns
            note_test($sformatf("store %0d at %h, %0d write(s)", row, rows[row].addr,
                                attempts), mark);
            row++;
            attempts = 0;
            done_rows = row;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: stores did not finish within %0d cycles", limit);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin : stimulus
      int mark;
      int accepted;
      void'($urandom(32'h5c702057));
      rows = '{
         '{32'h0000_1000, 32'h1111_1111, 4'hf, 2'd0},
         '{32'h0000_1004, 32'h2222_2222, 4'hf, 2'd0},
         '{32'h0000_2008, 32'hdead_beef, 4'h3, 2'd1},
         '{32'h0000_200c, 32'hcafe_f00d, 4'hc, 2'd0},
         '{32'h8000_0010, 32'h0123_4567, 4'h1, 2'd2},
         '{32'h8000_0014, 32'h89ab_cdef, 4'h8, 2'd0},
         '{32'hffff_fff8, 32'h5a5a_a5a5, 4'h6, 2'd1},
         '{32'h0000_3006, 32'h7e57_0bad, 4'h9, 2'd0}   // unaligned address in the upper lane
      };
      reset     = 1'b1;
      req_valid = 1'b0;
      req_addr  = '0;
      req_wdata = '0;
      req_wstrb = '0;
      awready   = 1'b0;
      wready    = 1'b0;
      bvalid    = 1'b0;
      bresp     = OKAY;
      stall     = 1'b1;
      accepted  = 0;
      limit     = timeout_cycles();
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      @(negedge clk);
      mark = errors;
      if (awvalid !== 1'b0 || wvalid !== 1'b0 || wlast !== 1'b0 || bready !== 1'b0) begin
         report_mismatch("awvalid, wvalid, wlast or bready high after reset");
      end
      if (req_ready !== 1'b1) begin
         report_mismatch("req_ready low after reset");
      end
      note_test("reset values", mark);
      @(posedge clk);
      #1;
      for (int i = 0; i < ROWS; i++) begin
         req_valid = 1'b1;
         req_addr  = rows[i].addr;
         req_wdata = rows[i].data;
         req_wstrb = rows[i].strb;
         @(negedge clk);
         while (req_ready !== 1'b1) begin
            if (stall) begin
               hold_full(accepted);
            end
            @(negedge clk);
         end
         @(posedge clk);
         #1 accepted++;
      end
      req_valid = 1'b0;
      if (stall) begin
         errors++;
         $display("error: req_ready never fell while the slave was stalled");
         stall = 1'b0;
      end
      while (done_rows < ROWS) @(negedge clk);
      mark = errors;
      repeat (10) begin
         @(negedge clk);
         if (awvalid !== 1'b0 || wvalid !== 1'b0 || wlast !== 1'b0) begin
            report_mismatch("extra AXI write after the last store");
         end
      end
      note_test("no extra writes", mark);
      $display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
   parameter int PERIOD = 8    // ns
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

endmodule

//--- verilog.f
+incdir+hdl
hdl/cache_req_pkg.sv
hdl/axi_wr_pkg.sv
hdl/wr_req_if.sv
hdl/write_buffer.sv
hdl/axi_write_channel.sv
hdl/cache_write_path.sv
testbench/tb_clock.sv
testbench/tb_cache_write_path.sv
